// File: cce_dir_pkg.sv
package cce_dir_pkg;

  // width of one coherence state field
  localparam int coh_bits_c = 3;

  // width of a directory operation code
  localparam int dir_op_bits_c = 3;

  // coherence states kept per entry
  typedef enum logic [coh_bits_c-1:0] {
    coh_invalid   = 3'd0,
    coh_shared    = 3'd1,
    coh_exclusive = 3'd2,
    coh_modified  = 3'd3,
    coh_owned     = 3'd4,
    coh_forward   = 3'd5
  } coh_state_e;

  // directory operations
  // codes 6 and 7 are not defined
  typedef enum logic [dir_op_bits_c-1:0] {
    // read pending bit of a way-group
    op_rdp = 3'd0,
    // read a whole way-group
    op_rdw = 3'd1,
    // read one entry
    op_rde = 3'd2,
    // write pending bit
    op_wdp = 3'd3,
    // write tag and state of one entry
    op_wde = 3'd4,
    // write state only, tag is kept
    op_wds = 3'd5
  } dir_op_e;

endpackage

// File: dir_cmd_if.sv
`timescale 1ns/1ps

interface dir_cmd_if #(
  parameter int num_way_groups_p = 16,
  parameter int num_lce_p        = 2,
  parameter int lce_assoc_p      = 4,
  parameter int tag_width_p      = 10
);

  localparam int lg_num_way_groups_lp = (num_way_groups_p > 1) ? $clog2(num_way_groups_p) : 1;
  localparam int lg_num_lce_lp        = (num_lce_p > 1) ? $clog2(num_lce_p) : 1;
  localparam int lg_lce_assoc_lp      = (lce_assoc_p > 1) ? $clog2(lce_assoc_p) : 1;

  // registered command, one per cycle
  logic                            v;
  cce_dir_pkg::dir_op_e            op;
  logic [lg_num_way_groups_lp-1:0] way_group;
  logic [lg_num_lce_lp-1:0]        lce;
  logic [lg_lce_assoc_lp-1:0]      way;
  logic [tag_width_p-1:0]          tag;
  cce_dir_pkg::coh_state_e         coh_state;
  logic                            pending;

  modport src (output v, op, way_group, lce, way, tag, coh_state, pending);

  modport dst (input v, op, way_group, lce, way, tag, coh_state, pending);

endinterface

// File: dir_cmd_stage.sv
`timescale 1ns/1ps

module dir_cmd_stage #(
  parameter int num_way_groups_p = 16,
  parameter int num_lce_p        = 2,
  parameter int lce_assoc_p      = 4,
  parameter int tag_width_p      = 10,
  localparam int lg_num_way_groups_lp = (num_way_groups_p > 1) ? $clog2(num_way_groups_p) : 1,
  localparam int lg_num_lce_lp        = (num_lce_p > 1) ? $clog2(num_lce_p) : 1,
  localparam int lg_lce_assoc_lp      = (lce_assoc_p > 1) ? $clog2(lce_assoc_p) : 1
) (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  logic                            cmd_v_i,
  input  cce_dir_pkg::dir_op_e            cmd_op_i,
  input  logic [lg_num_way_groups_lp-1:0] way_group_i,
  input  logic [lg_num_lce_lp-1:0]        lce_i,
  input  logic [lg_lce_assoc_lp-1:0]      way_i,
  input  logic [tag_width_p-1:0]          tag_i,
  input  cce_dir_pkg::coh_state_e         coh_state_i,
  input  logic                            pending_i,
  dir_cmd_if.src                          cmd
);

  logic op_legal;
  logic in_range;
  logic accept;

  // classify the op code, only the six defined ops pass
  always_comb begin
    case (cmd_op_i)
      cce_dir_pkg::op_rdp,
      cce_dir_pkg::op_rdw,
      cce_dir_pkg::op_rde,
      cce_dir_pkg::op_wdp,
      cce_dir_pkg::op_wde,
      cce_dir_pkg::op_wds: op_legal = 1'b1;
      default:             op_legal = 1'b0;
    endcase
  end

  assign in_range = (way_group_i < num_way_groups_p) && (lce_i < num_lce_p)
                    && (way_i < lce_assoc_p);

  // illegal commands are dropped here
  assign accept = cmd_v_i & op_legal & in_range;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cmd.v <= 1'b0;
    end else begin
      cmd.v <= accept;
    end
  end

  // payload only loads with a valid command
  always_ff @(posedge clk_i) begin
    if (cmd_v_i) begin
      cmd.op        <= cmd_op_i;
      cmd.way_group <= way_group_i;
      cmd.lce       <= lce_i;
      cmd.way       <= way_i;
      cmd.tag       <= tag_i;
      cmd.coh_state <= coh_state_i;
      cmd.pending   <= pending_i;
    end
  end

  // upstream must only issue defined ops on existing caches and ways
  a_cmd_legal: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    cmd_v_i |-> op_legal && in_range)
    else $error("dir_cmd_stage: illegal directory command");

endmodule

// File: dir_pending_bits.sv
`timescale 1ns/1ps

module dir_pending_bits #(
  parameter int num_way_groups_p = 16
) (
  input  logic   clk_i,
  input  logic   arst_n_i,
  dir_cmd_if.dst cmd,
  output logic   pending_o,
  output logic   pending_v_o
);

  logic [num_way_groups_p-1:0] pending_r;
  logic                        pending_w;
  logic                        pending_r_v;

  assign pending_w   = cmd.v & (cmd.op == cce_dir_pkg::op_wdp);
  assign pending_r_v = cmd.v & (cmd.op == cce_dir_pkg::op_rdp);

  // one pending flop per way-group
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_r <= '0;
    end else if (pending_w) begin
      pending_r[cmd.way_group] <= cmd.pending;
    end
  end

  // same cycle read off the registered command
  assign pending_o   = pending_r[cmd.way_group];
  assign pending_v_o = pending_r_v;

  // index comes from the command stage and must hit a real flop
  a_wg_in_range: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    cmd.v |-> (cmd.way_group < num_way_groups_p))
    else $error("dir_pending_bits: way-group index out of range");

endmodule

// File: dir_wg_ram.sv
`timescale 1ns/1ps

module dir_wg_ram #(
  parameter int num_way_groups_p = 16,
  parameter int num_lce_p        = 2,
  parameter int lce_assoc_p      = 4,
  parameter int tag_width_p      = 10,
  localparam int entry_width_lp     = tag_width_p + cce_dir_pkg::coh_bits_c,
  localparam int tag_set_width_lp   = entry_width_lp * lce_assoc_p,
  localparam int way_group_width_lp = tag_set_width_lp * num_lce_p
) (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  dir_cmd_if.dst                        cmd,
  output logic [way_group_width_lp-1:0] way_group_o
);

  localparam int lg_num_way_groups_lp = (num_way_groups_p > 1) ? $clog2(num_way_groups_p) : 1;

  // unshifted masks for a full entry and for the state field alone
  localparam logic [way_group_width_lp-1:0] entry_ones_lp =
    {{(way_group_width_lp-entry_width_lp){1'b0}}, {entry_width_lp{1'b1}}};
  localparam logic [way_group_width_lp-1:0] state_ones_lp =
    {{(way_group_width_lp-cce_dir_pkg::coh_bits_c){1'b0}}, {cce_dir_pkg::coh_bits_c{1'b1}}};

  logic                            ram_r;
  logic                            ram_w;
  logic                            ram_v;
  logic [lg_num_way_groups_lp-1:0] ram_addr;
  logic [31:0]                     entry_offset;
  logic [way_group_width_lp-1:0]   w_mask;
  logic [way_group_width_lp-1:0]   w_data;
  logic [way_group_width_lp-1:0]   rd_data_r;
  logic [way_group_width_lp-1:0]   mem_r [num_way_groups_p];

  assign ram_r = cmd.v & ((cmd.op == cce_dir_pkg::op_rdw) | (cmd.op == cce_dir_pkg::op_rde));
  assign ram_w = cmd.v & ((cmd.op == cce_dir_pkg::op_wde) | (cmd.op == cce_dir_pkg::op_wds));
  assign ram_v = ram_r | ram_w;

  // idle address parked at zero
  assign ram_addr = ram_v ? cmd.way_group : '0;

  // bit position of the entry, lce selects the tag set, way the entry in it
  assign entry_offset = cmd.lce * tag_set_width_lp + cmd.way * entry_width_lp;

  always_comb begin
    case (cmd.op)
      cce_dir_pkg::op_wde: w_mask = entry_ones_lp << entry_offset;
      cce_dir_pkg::op_wds: w_mask = state_ones_lp << entry_offset;
      default:             w_mask = '0;
    endcase
  end

  // state sits in the low bits of an entry, tag above it
  assign w_data = {{(way_group_width_lp-entry_width_lp){1'b0}}, cmd.tag, cmd.coh_state}
                  << entry_offset;

  // single port, either a masked write or a read per access
  always_ff @(posedge clk_i) begin
    if (ram_v) begin
      if (ram_w) begin
        mem_r[ram_addr] <= (mem_r[ram_addr] & ~w_mask) | (w_data & w_mask);
      end else begin
        rd_data_r <= mem_r[ram_addr];
      end
    end
  end

  assign way_group_o = rd_data_r;

  // an lce or way past the end would shift the mask out of the row
  a_write_mask_nonzero: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ram_w |-> (w_mask != '0))
    else $error("dir_wg_ram: write command produced an empty mask");

endmodule

// File: dir_entry_select.sv
`timescale 1ns/1ps

module dir_entry_select #(
  parameter int num_lce_p   = 2,
  parameter int lce_assoc_p = 4,
  parameter int tag_width_p = 10,
  localparam int entry_width_lp     = tag_width_p + cce_dir_pkg::coh_bits_c,
  localparam int tag_set_width_lp   = entry_width_lp * lce_assoc_p,
  localparam int way_group_width_lp = tag_set_width_lp * num_lce_p
) (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  dir_cmd_if.dst                        cmd,
  input  logic [way_group_width_lp-1:0] way_group_i,
  output logic [tag_width_p-1:0]        tag_o,
  output cce_dir_pkg::coh_state_e       coh_state_o,
  output logic                          entry_v_o,
  output logic                          way_group_v_o
);

  localparam int lg_num_lce_lp   = (num_lce_p > 1) ? $clog2(num_lce_p) : 1;
  localparam int lg_lce_assoc_lp = (lce_assoc_p > 1) ? $clog2(lce_assoc_p) : 1;

  logic                          wg_read;
  logic                          entry_read;
  logic                          entry_v_r;
  logic                          wg_v_r;
  logic [lg_num_lce_lp-1:0]      lce_r;
  logic [lg_lce_assoc_lp-1:0]    way_r;
  logic [tag_set_width_lp-1:0]   tag_set;
  logic [entry_width_lp-1:0]     entry;

  assign wg_read = cmd.v & ((cmd.op == cce_dir_pkg::op_rdw) | (cmd.op == cce_dir_pkg::op_rde));
  assign entry_read = cmd.v & (cmd.op == cce_dir_pkg::op_rde);

  // valids line up with the memory read data
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      entry_v_r <= 1'b0;
      wg_v_r    <= 1'b0;
    end else begin
      entry_v_r <= entry_read;
      wg_v_r    <= wg_read;
    end
  end

  // entry coordinates follow the read by one cycle
  always_ff @(posedge clk_i) begin
    if (entry_read) begin
      lce_r <= cmd.lce;
      way_r <= cmd.way;
    end
  end

  assign tag_set = way_group_i[lce_r*tag_set_width_lp +: tag_set_width_lp];
  assign entry   = tag_set[way_r*entry_width_lp +: entry_width_lp];

  assign tag_o       = entry[cce_dir_pkg::coh_bits_c +: tag_width_p];
  assign coh_state_o = cce_dir_pkg::coh_state_e'(entry[0 +: cce_dir_pkg::coh_bits_c]);

  assign entry_v_o     = entry_v_r;
  assign way_group_v_o = wg_v_r;

  // an entry result always comes with its way-group read
  a_entry_implies_wg: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    entry_v_o |-> way_group_v_o)
    else $error("dir_entry_select: entry valid without way-group read");

endmodule

// File: cce_dir_top.sv
`timescale 1ns/1ps

module cce_dir_top #(
  parameter int num_way_groups_p = 16,
  parameter int num_lce_p        = 2,
  parameter int lce_assoc_p      = 4,
  parameter int tag_width_p      = 10,
  localparam int lg_num_way_groups_lp = (num_way_groups_p > 1) ? $clog2(num_way_groups_p) : 1,
  localparam int lg_num_lce_lp        = (num_lce_p > 1) ? $clog2(num_lce_p) : 1,
  localparam int lg_lce_assoc_lp      = (lce_assoc_p > 1) ? $clog2(lce_assoc_p) : 1,
  localparam int entry_width_lp       = tag_width_p + cce_dir_pkg::coh_bits_c,
  localparam int tag_set_width_lp     = entry_width_lp * lce_assoc_p,
  localparam int way_group_width_lp   = tag_set_width_lp * num_lce_p
) (
  input  logic                            clk_i,
  input  logic                            arst_n_i,

  // command
  input  logic                            cmd_v_i,
  input  cce_dir_pkg::dir_op_e            cmd_op_i,
  input  logic [lg_num_way_groups_lp-1:0] way_group_i,
  input  logic [lg_num_lce_lp-1:0]        lce_i,
  input  logic [lg_lce_assoc_lp-1:0]      way_i,
  input  logic [tag_width_p-1:0]          tag_i,
  input  cce_dir_pkg::coh_state_e         coh_state_i,
  input  logic                            pending_i,

  // read results
  output logic                            pending_o,
  output logic                            pending_v_o,
  output logic [tag_width_p-1:0]          tag_o,
  output cce_dir_pkg::coh_state_e         coh_state_o,
  output logic                            entry_v_o,
  output logic [way_group_width_lp-1:0]   way_group_o,
  output logic                            way_group_v_o
);

  dir_cmd_if #(
    .num_way_groups_p(num_way_groups_p),
    .num_lce_p       (num_lce_p),
    .lce_assoc_p     (lce_assoc_p),
    .tag_width_p     (tag_width_p)
  ) cmd_if ();

  dir_cmd_stage #(
    .num_way_groups_p(num_way_groups_p),
    .num_lce_p       (num_lce_p),
    .lce_assoc_p     (lce_assoc_p),
    .tag_width_p     (tag_width_p)
  ) u_cmd_stage (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .cmd_v_i    (cmd_v_i),
    .cmd_op_i   (cmd_op_i),
    .way_group_i(way_group_i),
    .lce_i      (lce_i),
    .way_i      (way_i),
    .tag_i      (tag_i),
    .coh_state_i(coh_state_i),
    .pending_i  (pending_i),
    .cmd        (cmd_if.src)
  );

  dir_pending_bits #(
    .num_way_groups_p(num_way_groups_p)
  ) u_pending_bits (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .cmd        (cmd_if.dst),
    .pending_o  (pending_o),
    .pending_v_o(pending_v_o)
  );

  dir_wg_ram #(
    .num_way_groups_p(num_way_groups_p),
    .num_lce_p       (num_lce_p),
    .lce_assoc_p     (lce_assoc_p),
    .tag_width_p     (tag_width_p)
  ) u_wg_ram (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .cmd        (cmd_if.dst),
    .way_group_o(way_group_o)
  );

  // picks the addressed entry out of the row just read
  dir_entry_select #(
    .num_lce_p  (num_lce_p),
    .lce_assoc_p(lce_assoc_p),
    .tag_width_p(tag_width_p)
  ) u_entry_select (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .cmd          (cmd_if.dst),
    .way_group_i  (way_group_o),
    .tag_o        (tag_o),
    .coh_state_o  (coh_state_o),
    .entry_v_o    (entry_v_o),
    .way_group_v_o(way_group_v_o)
  );

endmodule

// File: tb_cce_dir.sv
`timescale 1ns/1ps

module tb_cce_dir;

  localparam int num_way_groups_c = 16;
  localparam int num_lce_c        = 2;
  localparam int lce_assoc_c      = 4;
  localparam int tag_width_c      = 10;
  localparam int lg_wg_c          = $clog2(num_way_groups_c);
  localparam int lg_lce_c         = $clog2(num_lce_c);
  localparam int lg_way_c         = $clog2(lce_assoc_c);
  localparam int coh_bits_c       = cce_dir_pkg::coh_bits_c;
  localparam int entry_width_c    = tag_width_c + coh_bits_c;
  localparam int wg_width_c       = entry_width_c * lce_assoc_c * num_lce_c;
  localparam int drain_limit_c    = 50;
  localparam int random_ops_c     = 300;

  logic                    clk_i = 1'b0;
  logic                    arst_n_i;
  logic                    cmd_v_i;
  cce_dir_pkg::dir_op_e    cmd_op_i;
  logic [lg_wg_c-1:0]      way_group_i;
  logic [lg_lce_c-1:0]     lce_i;
  logic [lg_way_c-1:0]     way_i;
  logic [tag_width_c-1:0]  tag_i;
  cce_dir_pkg::coh_state_e coh_state_i;
  logic                    pending_i;

  logic                    pending_o;
  logic                    pending_v_o;
  logic [tag_width_c-1:0]  tag_o;
  cce_dir_pkg::coh_state_e coh_state_o;
  logic                    entry_v_o;
  logic [wg_width_c-1:0]   way_group_o;
  logic                    way_group_v_o;

  // reference model, keyed by way-group and by entry
  logic                     pend_m  [int];
  logic [entry_width_c-1:0] entry_m [int];

  // expected read results in issue order
  logic                     exp_pend_q  [$];
  logic [wg_width_c-1:0]    exp_row_q   [$];
  logic [tag_width_c-1:0]   exp_tag_q   [$];
  logic [coh_bits_c-1:0]    exp_state_q [$];
  logic                     exp_pend_head;
  logic [wg_width_c-1:0]    exp_row_head;
  logic [tag_width_c-1:0]   exp_tag_head;
  logic [coh_bits_c-1:0]    exp_state_head;

  // issued commands one and two edges after sampling
  logic                     s1_v  = 1'b0;
  logic                     s2_v  = 1'b0;
  cce_dir_pkg::dir_op_e     s1_op = cce_dir_pkg::op_rdp;
  cce_dir_pkg::dir_op_e     s2_op = cce_dir_pkg::op_rdp;

  int seed;

  always #10 clk_i = ~clk_i;

  cce_dir_top #(
    .num_way_groups_p(num_way_groups_c),
    .num_lce_p       (num_lce_c),
    .lce_assoc_p     (lce_assoc_c),
    .tag_width_p     (tag_width_c)
  ) UUT (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .cmd_v_i      (cmd_v_i),
    .cmd_op_i     (cmd_op_i),
    .way_group_i  (way_group_i),
    .lce_i        (lce_i),
    .way_i        (way_i),
    .tag_i        (tag_i),
    .coh_state_i  (coh_state_i),
    .pending_i    (pending_i),
    .pending_o    (pending_o),
    .pending_v_o  (pending_v_o),
    .tag_o        (tag_o),
    .coh_state_o  (coh_state_o),
    .entry_v_o    (entry_v_o),
    .way_group_o  (way_group_o),
    .way_group_v_o(way_group_v_o)
  );

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "stopped at first error");
  endtask

  function automatic int entry_key(input int wg, input int lce, input int way);
    return (wg * num_lce_c + lce) * lce_assoc_c + way;
  endfunction

  // entry sits at (lce * assoc + way) entries up the row, state in its low bits
  function automatic logic [wg_width_c-1:0] expected_row(input int wg);
    logic [wg_width_c-1:0] row;
    row = '0;
    for (int l = 0; l < num_lce_c; l++) begin
      for (int w = 0; w < lce_assoc_c; w++) begin
        row[(l * lce_assoc_c + w) * entry_width_c +: entry_width_c] = entry_m[entry_key(wg, l, w)];
      end
    end
    return row;
  endfunction

  task automatic refresh_heads();
    exp_pend_head  = (exp_pend_q.size() > 0) ? exp_pend_q[0] : 1'b0;
    exp_row_head   = (exp_row_q.size() > 0) ? exp_row_q[0] : '0;
    exp_tag_head   = (exp_tag_q.size() > 0) ? exp_tag_q[0] : '0;
    exp_state_head = (exp_state_q.size() > 0) ? exp_state_q[0] : '0;
  endtask

  // one command per call, back to back when called in a row
  task automatic issue(input cce_dir_pkg::dir_op_e op, input int wg, input int lce,
                       input int way, input logic [tag_width_c-1:0] tag,
                       input cce_dir_pkg::coh_state_e state, input logic pend);
    int                       key;
    logic [entry_width_c-1:0] old_entry;
    key = entry_key(wg, lce, way);
    @(posedge clk_i);
    cmd_v_i     <= 1'b1;
    cmd_op_i    <= op;
    way_group_i <= wg[lg_wg_c-1:0];
    lce_i       <= lce[lg_lce_c-1:0];
    way_i       <= way[lg_way_c-1:0];
    tag_i       <= tag;
    coh_state_i <= state;
    pending_i   <= pend;
    // model runs in program order, a write is seen by the next command's read
    old_entry = entry_m.exists(key) ? entry_m[key] : '0;
    case (op)
      cce_dir_pkg::op_rdp: exp_pend_q.push_back(pend_m.exists(wg) ? pend_m[wg] : 1'b0);
      cce_dir_pkg::op_rdw, cce_dir_pkg::op_rde: begin
        exp_row_q.push_back(expected_row(wg));
        exp_tag_q.push_back(old_entry[entry_width_c-1:coh_bits_c]);
        exp_state_q.push_back(old_entry[coh_bits_c-1:0]);
      end
      cce_dir_pkg::op_wdp: pend_m[wg] = pend;
      cce_dir_pkg::op_wde: entry_m[key] = {tag, state};
      cce_dir_pkg::op_wds: entry_m[key] = {old_entry[entry_width_c-1:coh_bits_c], state};
    endcase
    refresh_heads();
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk_i);
      cmd_v_i <= 1'b0;
    end
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while ((exp_pend_q.size() != 0 || exp_row_q.size() != 0) && cycles < drain_limit_c) begin
      @(posedge clk_i);
      cycles++;
    end
    if (exp_pend_q.size() != 0 || exp_row_q.size() != 0) begin
      fail_run("Timeout: expected read results were never returned by the directory");
    end else begin
      // the last result is checked at the edge that drained it
      @(posedge clk_i);
    end
  endtask

  // drop each expected result at the edge where it is checked
  always @(posedge clk_i) begin
    if (pending_v_o === 1'b1) begin
      void'(exp_pend_q.pop_front());
    end
    if (way_group_v_o === 1'b1) begin
      void'(exp_row_q.pop_front());
      void'(exp_tag_q.pop_front());
      void'(exp_state_q.pop_front());
    end
    refresh_heads();
    s1_v  <= cmd_v_i;
    s1_op <= cmd_op_i;
    s2_v  <= s1_v;
    s2_op <= s1_op;
  end

  a_pending_timing: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    pending_v_o === (s1_v && s1_op == cce_dir_pkg::op_rdp))
    else fail_run($sformatf("Mismatch at %0t ns: pending_v_o off its one edge slot", $time));

  a_wg_timing: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    way_group_v_o === (s2_v && (s2_op == cce_dir_pkg::op_rdw || s2_op == cce_dir_pkg::op_rde)))
    else fail_run($sformatf("Mismatch at %0t ns: way_group_v_o off its two edge slot", $time));

  a_entry_timing: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    entry_v_o === (s2_v && s2_op == cce_dir_pkg::op_rde))
    else fail_run($sformatf("Mismatch at %0t ns: entry_v_o off its two edge slot", $time));

  a_pending_value: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    pending_v_o |-> pending_o === exp_pend_head)
    else fail_run($sformatf("Mismatch at %0t ns: pending_o %b, expected %b", $time,
                            $sampled(pending_o), $sampled(exp_pend_head)));

  a_row_value: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    way_group_v_o |-> way_group_o === exp_row_head)
    else fail_run($sformatf("Mismatch at %0t ns: way_group_o %h, expected %h", $time,
                            $sampled(way_group_o), $sampled(exp_row_head)));

  a_entry_value: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    entry_v_o |-> (tag_o === exp_tag_head) && (coh_state_o === exp_state_head))
    else fail_run($sformatf("Mismatch at %0t ns: entry %h/%0d, expected %h/%0d", $time,
                            $sampled(tag_o), $sampled(coh_state_o),
                            $sampled(exp_tag_head), $sampled(exp_state_head)));

  initial begin
    int r_op;
    int r_wg;
    int r_lce;
    int r_way;
    int r_st;
    seed        = 44;
    arst_n_i    = 1'b0;
    cmd_v_i     = 1'b0;
    cmd_op_i    = cce_dir_pkg::op_rdp;
    way_group_i = '0;
    lce_i       = '0;
    way_i       = '0;
    tag_i       = '0;
    coh_state_i = cce_dir_pkg::coh_invalid;
    pending_i   = 1'b0;
    refresh_heads();
    repeat (4) @(posedge clk_i);
    arst_n_i <= 1'b1;

    // every pending bit reads back clear after reset
    for (int g = 0; g < num_way_groups_c; g++) begin
      pend_m[g] = 1'b0;
      issue(cce_dir_pkg::op_rdp, g, 0, 0, '0, cce_dir_pkg::coh_invalid, 1'b0);
    end

    // fill every entry, pattern from the full entry address
    for (int g = 0; g < num_way_groups_c; g++) begin
      for (int l = 0; l < num_lce_c; l++) begin
        for (int w = 0; w < lce_assoc_c; w++) begin
          issue(cce_dir_pkg::op_wde, g, l, w, tag_width_c'(entry_key(g, l, w) * 7 + 'h155),
                cce_dir_pkg::coh_state_e'(entry_key(g, l, w) % 6), 1'b0);
        end
      end
    end

    // pending write then neighbor reads
    issue(cce_dir_pkg::op_wdp, 5, 0, 0, '0, cce_dir_pkg::coh_invalid, 1'b1);
    issue(cce_dir_pkg::op_rdp, 5, 0, 0, '0, cce_dir_pkg::coh_invalid, 1'b0);
    issue(cce_dir_pkg::op_rdp, 4, 0, 0, '0, cce_dir_pkg::coh_invalid, 1'b0);
    issue(cce_dir_pkg::op_rdp, 6, 0, 0, '0, cce_dir_pkg::coh_invalid, 1'b0);
    issue(cce_dir_pkg::op_wdp, 5, 0, 0, '0, cce_dir_pkg::coh_invalid, 1'b0);
    issue(cce_dir_pkg::op_rdp, 5, 0, 0, '0, cce_dir_pkg::coh_invalid, 1'b0);

    // entry write, state only write with a tag that must be ignored
    issue(cce_dir_pkg::op_wde, 3, 1, 2, 10'h2a5, cce_dir_pkg::coh_modified, 1'b0);
    issue(cce_dir_pkg::op_rde, 3, 1, 2, '0, cce_dir_pkg::coh_invalid, 1'b0);
    issue(cce_dir_pkg::op_wds, 3, 1, 2, 10'h3ff, cce_dir_pkg::coh_owned, 1'b0);
    issue(cce_dir_pkg::op_rde, 3, 1, 2, '0, cce_dir_pkg::coh_invalid, 1'b0);

    // several slots of one row, neighbors keep the fill
    issue(cce_dir_pkg::op_wde, 7, 0, 0, 10'h0f1, cce_dir_pkg::coh_shared, 1'b0);
    issue(cce_dir_pkg::op_wde, 7, 1, 3, 10'h30c, cce_dir_pkg::coh_forward, 1'b0);
    issue(cce_dir_pkg::op_wds, 7, 0, 2, 10'h000, cce_dir_pkg::coh_exclusive, 1'b0);
    issue(cce_dir_pkg::op_rdw, 7, 0, 0, '0, cce_dir_pkg::coh_invalid, 1'b0);
    idle(3);
    wait_drain();

    // random back to back stream over all six ops
    for (int i = 0; i < random_ops_c; i++) begin
      r_op  = $unsigned($random(seed)) % 6;
      r_wg  = $unsigned($random(seed)) % num_way_groups_c;
      r_lce = $unsigned($random(seed)) % num_lce_c;
      r_way = $unsigned($random(seed)) % lce_assoc_c;
      r_st  = $unsigned($random(seed)) % 6;
      issue(cce_dir_pkg::dir_op_e'(r_op), r_wg, r_lce, r_way, tag_width_c'($random(seed)),
            cce_dir_pkg::coh_state_e'(r_st), 1'($random(seed)));
    end
    idle(3);
    wait_drain();

    $display("Verification passed");
    $finish;
  end

endmodule

// File: build.f
cce_dir_pkg.sv
dir_cmd_if.sv
dir_cmd_stage.sv
dir_pending_bits.sv
dir_wg_ram.sv
dir_entry_select.sv
cce_dir_top.sv
tb_cce_dir.sv
